// ==== hdl/mem_pkg.sv ====
package mem_pkg;

	// data and address width
	parameter int xlen = 32;

	// default RAM depth is 256 words
	parameter int def_addr_bits = 8;

	// funct3 sits at instruction[9:7]
	parameter int f3_lsb = 7;

	// load widths
	parameter logic [2:0] f3_lb  = 3'd0;
	parameter logic [2:0] f3_lh  = 3'd1;
	parameter logic [2:0] f3_lw  = 3'd2;
	parameter logic [2:0] f3_lbu = 3'd4;
	parameter logic [2:0] f3_lhu = 3'd5;

	// store widths
	parameter logic [2:0] f3_sb = 3'd0;
	parameter logic [2:0] f3_sh = 3'd1;
	parameter logic [2:0] f3_sw = 3'd2;

endpackage

// ==== hdl/lsu_decode_stage.sv ====
`timescale 1ns/1ps

module lsu_decode_stage (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     req,
	input  logic                     is_store,
	input  logic [mem_pkg::xlen-1:0] instruction,
	input  logic [mem_pkg::xlen-1:0] base,
	input  logic [mem_pkg::xlen-1:0] offset,
	input  logic [mem_pkg::xlen-1:0] store_data,
	input  logic [4:0]               rd,
	output logic                     d_valid,
	output logic                     d_store,
	output logic [2:0]               d_funct3,
	output logic [mem_pkg::xlen-1:0] d_addr,
	output logic [mem_pkg::xlen-1:0] d_data,
	output logic [4:0]               d_rd,
	output logic                     d_fault
);

	import mem_pkg::*;

	logic [2:0]      funct3;
	logic [xlen-1:0] eff_addr;
	logic            bad;

	assign funct3   = instruction[f3_lsb +: 3];
	assign eff_addr = base + offset;

	// misaligned halfword/word, or a code not defined for the direction
	always_comb begin
		if (is_store) begin
			case (funct3)
				f3_sb:   bad = 1'b0;
				f3_sh:   bad = eff_addr[0];
				f3_sw:   bad = |eff_addr[1:0];
				default: bad = 1'b1;
			endcase
		end else begin
			case (funct3)
				f3_lb, f3_lbu: bad = 1'b0;
				f3_lh, f3_lhu: bad = eff_addr[0];
				f3_lw:         bad = |eff_addr[1:0];
				default:       bad = 1'b1;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			d_valid <= 1'b0;
			d_fault <= 1'b0;
		end else begin
			d_valid <= req;
			d_fault <= req & bad;
		end
	end

	always_ff @(posedge clk) begin
		d_store  <= is_store;
		d_funct3 <= funct3;
		d_addr   <= eff_addr;
		d_data   <= store_data;
		d_rd     <= rd;
	end

	// byte accesses can never be misaligned
	a_byte_no_fault: assert property (
		@(posedge clk) disable iff (!rst_n)
		d_valid && (d_funct3 == f3_lb || (!d_store && d_funct3 == f3_lbu))
			|-> !d_fault
	);

endmodule

// ==== hdl/store_align_stage.sv ====
`timescale 1ns/1ps

module store_align_stage #(
	parameter int addr_bits = mem_pkg::def_addr_bits
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     d_valid,
	input  logic                     d_store,
	input  logic [2:0]               d_funct3,
	input  logic [mem_pkg::xlen-1:0] d_addr,
	input  logic [mem_pkg::xlen-1:0] d_data,
	input  logic [4:0]               d_rd,
	input  logic                     d_fault,
	output logic                     ram_we,
	output logic                     ram_re,
	output logic [addr_bits-1:0]     ram_addr,
	output logic [mem_pkg::xlen-1:0] ram_wdata,
	output logic [3:0]               ram_wmask,
	output logic                     a_valid,
	output logic                     a_store,
	output logic [2:0]               a_funct3,
	output logic [1:0]               a_lane,
	output logic [4:0]               a_rd,
	output logic                     a_fault
);

	import mem_pkg::*;

	logic [xlen-1:0] masked;
	logic [3:0]      mask;
	logic [1:0]      lane;

	// sideband while the request sits in front of the RAM
	logic            s_valid;
	logic            s_store;
	logic [2:0]      s_funct3;
	logic [1:0]      s_lane;
	logic [4:0]      s_rd;
	logic            s_fault;

	assign lane = d_addr[1:0];

	always_comb begin
		case (d_funct3)
			f3_sb: begin
				masked = {{(xlen-8){1'b0}}, d_data[7:0]};
				mask   = 4'b0001 << lane;
			end
			f3_sh: begin
				masked = {{(xlen-16){1'b0}}, d_data[15:0]};
				mask   = 4'b0011 << lane;
			end
			f3_sw: begin
				masked = d_data;
				mask   = 4'b1111;
			end
			default: begin
				masked = '0;
				mask   = 4'b0000;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ram_we  <= 1'b0;
			ram_re  <= 1'b0;
			s_valid <= 1'b0;
			s_fault <= 1'b0;
			a_valid <= 1'b0;
			a_fault <= 1'b0;
		end else begin
			ram_we  <= d_valid & d_store & ~d_fault;
			ram_re  <= d_valid & ~d_store & ~d_fault;
			s_valid <= d_valid;
			s_fault <= d_fault;
			a_valid <= s_valid;
			a_fault <= s_fault;
		end
	end

	always_ff @(posedge clk) begin
		ram_addr  <= d_addr[addr_bits+1:2];
		ram_wdata <= masked << {lane, 3'b000};
		ram_wmask <= mask;
		s_store   <= d_store;
		s_funct3  <= d_funct3;
		s_lane    <= lane;
		s_rd      <= d_rd;
		a_store   <= s_store;
		a_funct3  <= s_funct3;
		a_lane    <= s_lane;
		a_rd      <= s_rd;
	end

	a_we_re_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(ram_we && ram_re)
	);

	a_sb_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		ram_we && s_funct3 == f3_sb |-> $onehot(ram_wmask)
	);

endmodule

// ==== hdl/byte_ram.sv ====
`timescale 1ns/1ps

module byte_ram #(
	parameter int addr_bits = mem_pkg::def_addr_bits
) (
	input  logic                     clk,
	input  logic                     ram_we,
	input  logic                     ram_re,
	input  logic [addr_bits-1:0]     ram_addr,
	input  logic [mem_pkg::xlen-1:0] ram_wdata,
	input  logic [3:0]               ram_wmask,
	output logic [mem_pkg::xlen-1:0] ram_rdata
);

	import mem_pkg::*;

	localparam int depth = 1 << addr_bits;
	localparam int lanes = xlen / 8;

	logic [xlen-1:0] mem [depth];

	// per-lane write enables
	always_ff @(posedge clk) begin
		if (ram_we) begin
			for (int i = 0; i < lanes; i++) begin
				if (ram_wmask[i])
					mem[ram_addr][8*i +: 8] <= ram_wdata[8*i +: 8];
			end
		end
	end

	// registered read, holds between reads
	always_ff @(posedge clk) begin
		if (ram_re)
			ram_rdata <= mem[ram_addr];
	end

	a_wmask_nonzero: assert property (
		@(posedge clk)
		ram_we |-> ram_wmask != 4'b0000
	);

endmodule

// ==== hdl/load_extend_stage.sv ====
`timescale 1ns/1ps

module load_extend_stage (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     a_valid,
	input  logic                     a_store,
	input  logic [2:0]               a_funct3,
	input  logic [1:0]               a_lane,
	input  logic [4:0]               a_rd,
	input  logic                     a_fault,
	input  logic [mem_pkg::xlen-1:0] ram_rdata,
	output logic                     done,
	output logic                     fault,
	output logic                     load_valid,
	output logic [mem_pkg::xlen-1:0] load_data,
	output logic [4:0]               load_rd
);

	import mem_pkg::*;

	logic [7:0]      lane_byte;
	logic [15:0]     lane_half;
	logic [xlen-1:0] ext;
	logic            load_ok;

	assign load_ok = a_valid & ~a_store & ~a_fault;

	always_comb begin
		case (a_lane)
			2'd0:    lane_byte = ram_rdata[7:0];
			2'd1:    lane_byte = ram_rdata[15:8];
			2'd2:    lane_byte = ram_rdata[23:16];
			default: lane_byte = ram_rdata[31:24];
		endcase
	end

	// halfword lane is 0 or 2 once alignment is checked
	assign lane_half = a_lane[1] ? ram_rdata[31:16] : ram_rdata[15:0];

	always_comb begin
		case (a_funct3)
			f3_lb:   ext = {{(xlen-8){lane_byte[7]}}, lane_byte};
			f3_lbu:  ext = {{(xlen-8){1'b0}}, lane_byte};
			f3_lh:   ext = {{(xlen-16){lane_half[15]}}, lane_half};
			f3_lhu:  ext = {{(xlen-16){1'b0}}, lane_half};
			f3_lw:   ext = ram_rdata;
			default: ext = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done       <= 1'b0;
			fault      <= 1'b0;
			load_valid <= 1'b0;
		end else begin
			done       <= a_valid;
			fault      <= a_valid & a_fault;
			load_valid <= load_ok;
		end
	end

	// zero for stores and faulted requests
	always_ff @(posedge clk) begin
		load_data <= load_ok ? ext : '0;
		load_rd   <= a_rd;
	end

endmodule

// ==== hdl/mem_access_top.sv ====
`timescale 1ns/1ps

module mem_access_top #(
	parameter int addr_bits = mem_pkg::def_addr_bits
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     req,
	input  logic                     is_store,
	input  logic [mem_pkg::xlen-1:0] instruction,
	input  logic [mem_pkg::xlen-1:0] base,
	input  logic [mem_pkg::xlen-1:0] offset,
	input  logic [mem_pkg::xlen-1:0] store_data,
	input  logic [4:0]               rd,
	output logic                     done,
	output logic                     fault,
	output logic                     load_valid,
	output logic [mem_pkg::xlen-1:0] load_data,
	output logic [4:0]               load_rd
);

	import mem_pkg::*;

	logic                 d_valid;
	logic                 d_store;
	logic [2:0]           d_funct3;
	logic [xlen-1:0]      d_addr;
	logic [xlen-1:0]      d_data;
	logic [4:0]           d_rd;
	logic                 d_fault;

	logic                 ram_we;
	logic                 ram_re;
	logic [addr_bits-1:0] ram_addr;
	logic [xlen-1:0]      ram_wdata;
	logic [3:0]           ram_wmask;
	logic [xlen-1:0]      ram_rdata;

	logic                 a_valid;
	logic                 a_store;
	logic [2:0]           a_funct3;
	logic [1:0]           a_lane;
	logic [4:0]           a_rd;
	logic                 a_fault;

	lsu_decode_stage u_decode (
		.clk(clk), .rst_n(rst_n), .req(req), .is_store(is_store),
		.instruction(instruction), .base(base), .offset(offset),
		.store_data(store_data), .rd(rd),
		.d_valid(d_valid), .d_store(d_store), .d_funct3(d_funct3),
		.d_addr(d_addr), .d_data(d_data), .d_rd(d_rd), .d_fault(d_fault)
	);

	store_align_stage #(.addr_bits(addr_bits)) u_align (
		.clk(clk), .rst_n(rst_n),
		.d_valid(d_valid), .d_store(d_store), .d_funct3(d_funct3),
		.d_addr(d_addr), .d_data(d_data), .d_rd(d_rd), .d_fault(d_fault),
		.ram_we(ram_we), .ram_re(ram_re), .ram_addr(ram_addr),
		.ram_wdata(ram_wdata), .ram_wmask(ram_wmask),
		.a_valid(a_valid), .a_store(a_store), .a_funct3(a_funct3),
		.a_lane(a_lane), .a_rd(a_rd), .a_fault(a_fault)
	);

	byte_ram #(.addr_bits(addr_bits)) u_ram (
		.clk(clk), .ram_we(ram_we), .ram_re(ram_re), .ram_addr(ram_addr),
		.ram_wdata(ram_wdata), .ram_wmask(ram_wmask), .ram_rdata(ram_rdata)
	);

	load_extend_stage u_extend (
		.clk(clk), .rst_n(rst_n),
		.a_valid(a_valid), .a_store(a_store), .a_funct3(a_funct3),
		.a_lane(a_lane), .a_rd(a_rd), .a_fault(a_fault), .ram_rdata(ram_rdata),
		.done(done), .fault(fault), .load_valid(load_valid),
		.load_data(load_data), .load_rd(load_rd)
	);

endmodule

// ==== tb/mem_access_checker.sv ====
`timescale 1ns/1ps

module mem_access_checker #(
	parameter int addr_bits = mem_pkg::def_addr_bits
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [8*24-1:0]          name,
	input  logic                     req,
	input  logic                     is_store,
	input  logic [mem_pkg::xlen-1:0] instruction,
	input  logic [mem_pkg::xlen-1:0] base,
	input  logic [mem_pkg::xlen-1:0] offset,
	input  logic [mem_pkg::xlen-1:0] store_data,
	input  logic [4:0]               rd,
	input  logic                     done,
	input  logic                     fault,
	input  logic                     load_valid,
	input  logic [mem_pkg::xlen-1:0] load_data,
	input  logic [4:0]               load_rd,
	output int                       passes,
	output int                       fails,
	output int                       pending
);

	import mem_pkg::*;

	localparam int nbytes = 4 << addr_bits;

	// byte-addressed reference memory
	logic [7:0]      ref_mem [nbytes];
	int              cyc = 0;

	// expected completions, oldest first
	int              q_due [$];
	logic [8*24-1:0] q_name [$];
	logic            q_fault [$];
	logic            q_load [$];
	logic [xlen-1:0] q_data [$];
	logic [4:0]      q_rd [$];

	initial begin
		passes = 0;
		fails = 0;
		pending = 0;
	end

	function automatic string trim_name(input logic [8*24-1:0] v);
		string s;
		s = "";
		for (int i = 23; i >= 0; i--) begin
			if (v[8*i +: 8] != 8'h00)
				s = $sformatf("%s%c", s, v[8*i +: 8]);
		end
		return s;
	endfunction

	// bytes touched by the access, 0 for an undefined code
	function automatic int access_size(input logic st, input logic [2:0] f3);
		int n;
		n = 0;
		if (f3 == f3_lb || (!st && f3 == f3_lbu))
			n = 1;
		else if (f3 == f3_lh || (!st && f3 == f3_lhu))
			n = 2;
		else if (f3 == f3_lw)
			n = 4;
		return n;
	endfunction

	task automatic accept_request();
		logic [xlen-1:0] addr;
		logic [2:0]      f3;
		logic            bad;
		logic [xlen-1:0] value;
		int              size;
		int              idx;
		addr = base + offset;
		f3 = instruction[f3_lsb +: 3];
		size = access_size(is_store, f3);
		bad = (size == 0) ? 1'b1 : (addr[1:0] & 2'(size - 1)) != 2'b00;
		idx = int'(addr[addr_bits+1:0]);
		value = '0;
		if (!bad && is_store) begin
			for (int i = 0; i < size; i++)
				ref_mem[idx + i] = store_data[8*i +: 8];
		end else if (!bad) begin
			for (int i = 0; i < size; i++)
				value[8*i +: 8] = ref_mem[idx + i];
			if (f3 == f3_lb)
				value = {{(xlen-8){value[7]}}, value[7:0]};
			if (f3 == f3_lh)
				value = {{(xlen-16){value[15]}}, value[15:0]};
		end
		// req is taken at the next rising edge, done follows 3 edges later
		q_due.push_back(cyc + 4);
		q_name.push_back(name);
		q_fault.push_back(bad);
		q_load.push_back(!is_store && !bad);
		q_data.push_back(value);
		q_rd.push_back(rd);
	endtask

	task automatic check_outputs();
		logic ok;
		if (q_due.size() > 0 && q_due[0] == cyc) begin
			if (done !== 1'b1) begin
				$display("%s: no done pulse 3 cycles after the request",
					trim_name(q_name[0]));
				fails++;
			end else begin
				ok = fault === q_fault[0] && load_valid === q_load[0]
					&& load_data === q_data[0];
				if (q_load[0] && load_rd !== q_rd[0])
					ok = 1'b0;
				if (ok) begin
					passes++;
					$display("pass %s", trim_name(q_name[0]));
				end else begin
					fails++;
					$display("error %s: expected fault=%0b load_valid=%0b data=%h rd=%0d, %s",
						trim_name(q_name[0]), q_fault[0], q_load[0], q_data[0], q_rd[0],
						$sformatf("actual fault=%0b load_valid=%0b data=%h rd=%0d",
							fault, load_valid, load_data, load_rd));
				end
			end
			void'(q_due.pop_front());
			void'(q_name.pop_front());
			void'(q_fault.pop_front());
			void'(q_load.pop_front());
			void'(q_data.pop_front());
			void'(q_rd.pop_front());
		end else if (done !== 1'b0) begin
			$display("done pulse seen with no request due at this cycle");
			fails++;
		end
	endtask

	// inputs and outputs are both stable on the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			cyc = cyc + 1;
			check_outputs();
			if (req)
				accept_request();
			pending = q_due.size();
		end
	end

endmodule

// ==== tb/mem_access_tb.sv ====
`timescale 1ns/1ps

module mem_access_tb;

	import mem_pkg::*;

	localparam int addr_bits = def_addr_bits;
	localparam int latency = 3;
	localparam int margin = 20;

	logic            clk;
	logic            rst_n;
	logic            req;
	logic            is_store;
	logic [xlen-1:0] instruction;
	logic [xlen-1:0] base;
	logic [xlen-1:0] offset;
	logic [xlen-1:0] store_data;
	logic [4:0]      rd;
	logic [8*24-1:0] name;
	logic            done;
	logic            fault;
	logic            load_valid;
	logic [xlen-1:0] load_data;
	logic [4:0]      load_rd;
	int              passes;
	int              fails;
	int              pending;
	int              cycles = 0;
	int              limit = 0;
	int              n_requests = 0;

	// stimulus table, one row per cycle
	logic [8*24-1:0] t_name [$];
	logic            t_req [$];
	logic            t_store [$];
	logic [xlen-1:0] t_instr [$];
	logic [xlen-1:0] t_base [$];
	logic [xlen-1:0] t_offset [$];
	logic [xlen-1:0] t_data [$];
	logic [4:0]      t_rd [$];

	mem_access_top #(.addr_bits(addr_bits)) u_dut (
		.clk(clk), .rst_n(rst_n), .req(req), .is_store(is_store),
		.instruction(instruction), .base(base), .offset(offset),
		.store_data(store_data), .rd(rd), .done(done), .fault(fault),
		.load_valid(load_valid), .load_data(load_data), .load_rd(load_rd)
	);

	mem_access_checker #(.addr_bits(addr_bits)) u_chk (
		.clk(clk), .rst_n(rst_n), .name(name), .req(req), .is_store(is_store),
		.instruction(instruction), .base(base), .offset(offset),
		.store_data(store_data), .rd(rd), .done(done), .fault(fault),
		.load_valid(load_valid), .load_data(load_data), .load_rd(load_rd),
		.passes(passes), .fails(fails), .pending(pending)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// load or store opcode in bits 6..0, funct3 above it
	function automatic logic [xlen-1:0] make_instr(input logic st, input logic [2:0] f3);
		logic [xlen-1:0] w;
		w = st ? 32'h0000_0023 : 32'h0000_0003;
		w[f3_lsb +: 3] = f3;
		return w;
	endfunction

	task automatic add_row(input logic [8*24-1:0] n, input logic r, input logic st,
		input logic [2:0] f3, input logic [31:0] b, input logic [31:0] o,
		input logic [31:0] sd, input logic [4:0] dst);
		t_name.push_back(n);
		t_req.push_back(r);
		t_store.push_back(st);
		t_instr.push_back(make_instr(st, f3));
		t_base.push_back(b);
		t_offset.push_back(o);
		t_data.push_back(sd);
		t_rd.push_back(dst);
		if (r)
			n_requests++;
	endtask

	task automatic store_row(input logic [8*24-1:0] n, input logic [2:0] f3,
		input logic [31:0] b, input logic [31:0] o, input logic [31:0] sd);
		add_row(n, 1'b1, 1'b1, f3, b, o, sd, 5'd0);
	endtask

	task automatic load_row(input logic [8*24-1:0] n, input logic [2:0] f3,
		input logic [31:0] b, input logic [31:0] o, input logic [4:0] dst);
		add_row(n, 1'b1, 1'b0, f3, b, o, 32'h0, dst);
	endtask

	task automatic idle_row();
		add_row("idle", 1'b0, 1'b0, 3'd0, 32'h0, 32'h0, 32'h0, 5'd0);
	endtask

	task automatic build_table();
		store_row("sw_0x100", f3_sw, 32'h100, 32'h0, 32'hdead_beef);
		load_row("lw_next_cycle", f3_lw, 32'h100, 32'h0, 5'd5);
		idle_row();
		load_row("lw_base_offset", f3_lw, 32'h0f0, 32'h10, 5'd6);
		store_row("sw_neg_offset", f3_sw, 32'h120, 32'hffff_fffc, 32'h1234_5678);
		load_row("lw_neg_offset", f3_lw, 32'h11c, 32'h0, 5'd7);
		idle_row();
		// one byte lane at a time, the rest of the word kept
		store_row("sw_fill_0x200", f3_sw, 32'h200, 32'h0, 32'hffff_ffff);
		store_row("sb_lane0", f3_sb, 32'h200, 32'h0, 32'h0000_0011);
		store_row("sb_lane1", f3_sb, 32'h200, 32'h1, 32'hffff_ff22);
		load_row("lw_two_lanes", f3_lw, 32'h200, 32'h0, 5'd8);
		store_row("sb_lane2", f3_sb, 32'h202, 32'h0, 32'h5555_5533);
		store_row("sb_lane3", f3_sb, 32'h1ff, 32'h4, 32'h0000_0044);
		load_row("lw_all_lanes", f3_lw, 32'h200, 32'h0, 5'd9);
		idle_row();
		store_row("sh_lane0", f3_sh, 32'h300, 32'h0, 32'h0000_8001);
		store_row("sh_lane2", f3_sh, 32'h300, 32'h2, 32'h1234_7ffe);
		load_row("lh_lane0", f3_lh, 32'h300, 32'h0, 5'd10);
		load_row("lhu_lane0", f3_lhu, 32'h300, 32'h0, 5'd11);
		load_row("lh_lane2", f3_lh, 32'h302, 32'h0, 5'd12);
		load_row("lhu_lane2", f3_lhu, 32'h302, 32'h0, 5'd13);
		load_row("lw_halves", f3_lw, 32'h300, 32'h0, 5'd14);
		store_row("sw_bytes_0x40", f3_sw, 32'h40, 32'h0, 32'h80ff_7f01);
		load_row("lb_lane0", f3_lb, 32'h40, 32'h0, 5'd16);
		load_row("lbu_lane0", f3_lbu, 32'h40, 32'h0, 5'd17);
		load_row("lb_lane1", f3_lb, 32'h41, 32'h0, 5'd18);
		load_row("lbu_lane1", f3_lbu, 32'h41, 32'h0, 5'd19);
		load_row("lb_lane2", f3_lb, 32'h42, 32'h0, 5'd20);
		load_row("lbu_lane2", f3_lbu, 32'h42, 32'h0, 5'd21);
		load_row("lb_lane3", f3_lb, 32'h40, 32'h3, 5'd22);
		load_row("lbu_lane3", f3_lbu, 32'h40, 32'h3, 5'd23);
		// misaligned and undefined accesses leave memory alone
		load_row("lh_odd_fault", f3_lh, 32'h300, 32'h1, 5'd24);
		store_row("sw_misaligned", f3_sw, 32'h300, 32'h2, 32'h0bad_0bad);
		store_row("sh_odd_fault", f3_sh, 32'h303, 32'h0, 32'h0000_ffff);
		load_row("load_bad_funct3", 3'd3, 32'h300, 32'h0, 5'd25);
		load_row("lw_unchanged", f3_lw, 32'h300, 32'h0, 5'd26);
		idle_row();
		// back to back, four in flight
		store_row("bb_sw", f3_sw, 32'h80, 32'h0, 32'h0102_0304);
		load_row("bb_lw", f3_lw, 32'h80, 32'h0, 5'd27);
		store_row("bb_sb", f3_sb, 32'h81, 32'h0, 32'h0000_00aa);
		load_row("bb_lbu", f3_lbu, 32'h81, 32'h0, 5'd28);
		store_row("bb_sh", f3_sh, 32'h82, 32'h0, 32'h0000_beef);
		load_row("bb_lw_merged", f3_lw, 32'h80, 32'h0, 5'd29);
		load_row("bb_lh", f3_lh, 32'h82, 32'h0, 5'd30);
		store_row("bb_sw_next", f3_sw, 32'h84, 32'h0, 32'hcafe_f00d);
		load_row("bb_lb_top", f3_lb, 32'h87, 32'h0, 5'd31);
		load_row("bb_lw_next", f3_lw, 32'h84, 32'h0, 5'd1);
	endtask

	initial begin
		rst_n = 1'b0;
		req = 1'b0;
		is_store = 1'b0;
		instruction = '0;
		base = '0;
		offset = '0;
		store_data = '0;
		rd = '0;
		name = '0;
		build_table();
		limit = t_req.size() + latency + margin;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < t_req.size(); i++) begin
			@(posedge clk);
			name <= t_name[i];
			req <= t_req[i];
			is_store <= t_store[i];
			instruction <= t_instr[i];
			base <= t_base[i];
			offset <= t_offset[i];
			store_data <= t_data[i];
			rd <= t_rd[i];
		end
		@(posedge clk);
		req <= 1'b0;
		@(posedge clk);
		while (pending != 0)
			@(posedge clk);
		if (passes + fails != n_requests)
			$display("checker saw %0d results for %0d requests", passes + fails, n_requests);
		$display("%0d tests, %0d passed, %0d failed", passes + fails, passes, fails);
		if (fails == 0 && passes == n_requests)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	always @(posedge clk) begin
		if (rst_n) begin
			cycles <= cycles + 1;
			if (cycles > limit) begin
				$display("timeout: requests still outstanding after %0d cycles", cycles);
				$display("TEST FAILED");
				$finish;
			end
		end
	end

endmodule

// ==== files.f ====
hdl/mem_pkg.sv
hdl/lsu_decode_stage.sv
hdl/store_align_stage.sv
hdl/byte_ram.sv
hdl/load_extend_stage.sv
hdl/mem_access_top.sv
tb/mem_access_checker.sv
tb/mem_access_tb.sv
